/* compile.f */
+incdir+logic
logic/dnc_read_pkg.sv
logic/interface_row_sequencer.sv
logic/interface_operand_fetch.sv
logic/interface_mac_stage.sv
logic/interface_result_scaler.sv
logic/dnc_read_interface.sv
bench/clock_reset_gen.sv
bench/dnc_read_interface_tb.sv

/* bench/dnc_read_interface_tb.sv */
`default_nettype none

`include "dnc_read_params.svh"

module dnc_read_interface_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROWS = `DNC_ROW_COUNT;
  localparam int L = `DNC_HIDDEN_SIZE;
  localparam int KEY_ROWS = `DNC_READ_HEADS * `DNC_WORD_SIZE;
  // Cycle limit for any single wait
  localparam int WAIT_LIMIT = 200;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  logic                        w_wr;
  logic [`DNC_WADDR_BITS-1:0]  w_addr;
  logic [`DNC_DATA_WIDTH-1:0]  w_data;
  logic                        h_wr;
  logic [`DNC_HIDDEN_BITS-1:0] h_addr;
  logic [`DNC_DATA_WIDTH-1:0]  h_data;
  logic                        busy;
  logic                        xi_valid;
  dnc_read_pkg::xi_entry_t     xi;
  logic                        done;

  // Host copies of U and h, entries of the last pass
  logic signed [`DNC_DATA_WIDTH-1:0] weights [ROWS*L];
  logic signed [`DNC_DATA_WIDTH-1:0] hidden [L];
  dnc_read_pkg::xi_entry_t           got [ROWS];
  integer                            seed;

  clock_reset_gen clock_reset_gen_i (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_read_interface dut_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .w_wr     (w_wr),
    .w_addr   (w_addr),
    .w_data   (w_data),
    .h_wr     (h_wr),
    .h_addr   (h_addr),
    .h_data   (h_data),
    .busy     (busy),
    .xi_valid (xi_valid),
    .xi       (xi),
    .done     (done)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure handling and checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  // X on an output counts as a mismatch
  task automatic check_value(input string what, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %0t: %s expected %0d got %0d", $time, what, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic dnc_read_pkg::xi_entry_t expected_entry(input int row);
    dnc_read_pkg::xi_entry_t e;
    longint                  acc;
    int                      k;
    acc = 0;
    // Exact dot product, then Q16 back to Q8
    for (k = 0; k < L; k++) begin
      acc += longint'(weights[row*L+k]) * longint'(hidden[k]);
    end
    acc = acc >>> `DNC_FRAC_BITS;
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    e.value = 16'(acc);
    e.elem = 2'd0;
    // Row layout table
    if (row < KEY_ROWS) begin
      e.field = dnc_read_pkg::FIELD_KEY;
      e.head  = 1'(row / `DNC_WORD_SIZE);
      e.elem  = 2'(row % `DNC_WORD_SIZE);
    end else if (row < KEY_ROWS + `DNC_READ_HEADS) begin
      e.field = dnc_read_pkg::FIELD_STRENGTH;
      e.head  = 1'(row - KEY_ROWS);
    end else if (row < KEY_ROWS + 2 * `DNC_READ_HEADS) begin
      e.field = dnc_read_pkg::FIELD_FREE;
      e.head  = 1'(row - KEY_ROWS - `DNC_READ_HEADS);
    end else begin
      e.field = dnc_read_pkg::FIELD_MODE;
      e.head  = 1'((row - KEY_ROWS - 2 * `DNC_READ_HEADS) / `DNC_MODE_COUNT);
      e.elem  = 2'((row - KEY_ROWS - 2 * `DNC_READ_HEADS) % `DNC_MODE_COUNT);
    end
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Host writes and pass runner
  //////////////////////////////////////////////////////////////////////

  task automatic load_weights();
    int i;
    for (i = 0; i < ROWS * L; i++) begin
      @(negedge CLK);
      w_wr   = 1'b1;
      w_addr = `DNC_WADDR_BITS'(i);
      w_data = weights[i];
    end
    @(negedge CLK);
    w_wr = 1'b0;
  endtask

  task automatic load_hidden();
    int i;
    for (i = 0; i < L; i++) begin
      @(negedge CLK);
      h_wr   = 1'b1;
      h_addr = `DNC_HIDDEN_BITS'(i);
      h_data = hidden[i];
    end
    @(negedge CLK);
    h_wr = 1'b0;
  endtask

  // Extra START lands on edge restart_edge, none when negative
  task automatic run_pass(input int restart_edge);
    int                      n;
    int                      e;
    int                      count;
    int                      done_edge;
    int                      fall_edge;
    int                      r;
    dnc_read_pkg::xi_entry_t exp;
    n = 0;
    while (busy !== 1'b0) begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) abort_run("busy stayed high before the pass could start");
    end
    @(negedge CLK);
    start = 1'b1;
    // Edge 0 samples START
    @(negedge CLK);
    start = 1'b0;
    e = 0;
    count = 0;
    done_edge = -1;
    fall_edge = -1;
    // Keep watching a while after done for stray entries
    while (done_edge < 0 || e < done_edge + 12) begin
      @(negedge CLK);
      e++;
      start = (e + 1 == restart_edge);
      if (e > WAIT_LIMIT) abort_run("no done strobe arrived within the pass timeout");
      if (e == 1) check_value("busy after start", busy, 1);
      if (fall_edge < 0 && busy === 1'b0) begin
        fall_edge = e;
      end else if (fall_edge >= 0) begin
        check_value("busy after pass end", busy, 0);
      end
      if (xi_valid === 1'b1) begin
        if (count >= ROWS) abort_run("the DUT produced more entries than interface rows");
        check_value("entry arrival edge", e, 4 * count + 8);
        got[count] = xi;
        count++;
      end
      if (done === 1'b1) begin
        if (done_edge >= 0) abort_run("a second done strobe came in one pass");
        check_value("done edge", e, 76);
        check_value("entries at done", count, ROWS);
        done_edge = e;
      end
    end
    // Sequencer drains after beat 71
    check_value("busy fall edge", fall_edge, 73);
    check_value("entry count", count, ROWS);
    for (r = 0; r < ROWS; r++) begin
      exp = expected_entry(r);
      check_value($sformatf("row %0d field", r), got[r].field, exp.field);
      check_value($sformatf("row %0d head", r), got[r].head, exp.head);
      check_value($sformatf("row %0d elem", r), got[r].elem, exp.elem);
      check_value($sformatf("row %0d value", r), $signed(got[r].value), $signed(exp.value));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int n;
    n = 0;
    while (RST !== 1'b0) begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) abort_run("reset was never released");
    end
    // Idle with no START
    repeat (8) begin
      @(negedge CLK);
      check_value("busy idle", busy, 0);
      check_value("xi_valid idle", xi_valid, 0);
      check_value("done idle", done, 0);
    end
  endtask

  task automatic test_directed_pass();
    int i;
    // Small multiples of 48, both signs
    for (i = 0; i < ROWS * L; i++) begin
      weights[i] = 16'(((i % 7) - 3) * 48);
    end
    // 1.0, -0.5, 0.25, 2.0 in Q8
    hidden[0] = 16'sd256;
    hidden[1] = -16'sd128;
    hidden[2] = 16'sd64;
    hidden[3] = 16'sd512;
    load_weights();
    load_hidden();
    run_pass(-1);
  endtask

  task automatic test_saturation();
    int i;
    int k;
    hidden[0] = 16'sd32767;
    hidden[1] = -16'sd32768;
    hidden[2] = 16'sd32767;
    hidden[3] = -16'sd32768;
    for (i = 0; i < ROWS * L; i++) begin
      weights[i] = 16'((i % 5) - 2);
    end
    // Rows 3 and 12 overflow high, rows 9 and 17 overflow low
    for (k = 0; k < L; k++) begin
      weights[3*L+k]  = k[0] ? -16'sd32768 : 16'sd32767;
      weights[12*L+k] = k[0] ? -16'sd32768 : 16'sd32767;
      weights[9*L+k]  = k[0] ? 16'sd32767 : -16'sd32768;
      weights[17*L+k] = k[0] ? 16'sd32767 : -16'sd32768;
    end
    load_weights();
    load_hidden();
    run_pass(-1);
    check_value("row 3 high clamp", $signed(got[3].value), 32767);
    check_value("row 12 high clamp", $signed(got[12].value), 32767);
    check_value("row 9 low clamp", $signed(got[9].value), -32768);
    check_value("row 17 low clamp", $signed(got[17].value), -32768);
  endtask

  task automatic test_random_operands();
    int                                i;
    int                                changed;
    logic signed [`DNC_DATA_WIDTH-1:0] first [ROWS];
    // About +-2048 so some rows still clamp
    for (i = 0; i < ROWS * L; i++) begin
      weights[i] = 16'($random(seed) >>> 20);
    end
    for (i = 0; i < L; i++) begin
      hidden[i] = 16'($random(seed) >>> 20);
    end
    load_weights();
    load_hidden();
    run_pass(-1);
    for (i = 0; i < ROWS; i++) begin
      first[i] = got[i].value;
    end
    // New h only, U stays
    for (i = 0; i < L; i++) begin
      hidden[i] = 16'($random(seed) >>> 20);
    end
    load_hidden();
    run_pass(-1);
    changed = 0;
    for (i = 0; i < ROWS; i++) begin
      if (got[i].value !== first[i]) changed++;
    end
    check_value("second pass follows new h", changed > 0, 1);
  endtask

  task automatic test_start_while_busy();
    // Mid-pass, and on the edge after the last beat while still busy
    run_pass(30);
    run_pass(73);
  endtask

  initial begin
    seed = 32'hd1843391;
    start = 1'b0;
    w_wr = 1'b0;
    w_addr = '0;
    w_data = '0;
    h_wr = 1'b0;
    h_addr = '0;
    h_data = '0;
    test_reset_state();
    test_directed_pass();
    test_saturation();
    test_random_operands();
    test_start_while_busy();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/clock_reset_gen.sv */
`default_nettype none

module clock_reset_gen (
  output logic CLK,
  output logic RST
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Three rising edges of reset, released between edges
  initial begin
    RST = 1'b1;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

`default_nettype wire

/* logic/dnc_read_interface.sv */
`default_nettype none

`include "dnc_read_params.svh"

module dnc_read_interface (
  input  logic                        CLK,
  input  logic                        RST,
  // Pass control
  input  logic                        start,
  // Weight write port
  input  logic                        w_wr,
  input  logic [`DNC_WADDR_BITS-1:0]  w_addr,
  input  logic [`DNC_DATA_WIDTH-1:0]  w_data,
  // Hidden vector write port
  input  logic                        h_wr,
  input  logic [`DNC_HIDDEN_BITS-1:0] h_addr,
  input  logic [`DNC_DATA_WIDTH-1:0]  h_data,
  // Status and results
  output logic                        busy,
  output logic                        xi_valid,
  output dnc_read_pkg::xi_entry_t     xi,
  output logic                        done
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  logic                    beat_valid;
  dnc_read_pkg::row_beat_t beat;

  logic                   opnd_valid;
  dnc_read_pkg::operand_t opnd;

  logic                   sum_valid;
  dnc_read_pkg::row_sum_t sum;

  //////////////////////////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////////////////////////

  // One beat per weight, row-major
  interface_row_sequencer row_sequencer_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .busy       (busy),
    .beat_valid (beat_valid),
    .beat       (beat)
  );

  // U and h live here
  interface_operand_fetch operand_fetch_i (
    .CLK        (CLK),
    .RST        (RST),
    .w_wr       (w_wr),
    .w_addr     (w_addr),
    .w_data     (w_data),
    .h_wr       (h_wr),
    .h_addr     (h_addr),
    .h_data     (h_data),
    .beat_valid (beat_valid),
    .beat       (beat),
    .opnd_valid (opnd_valid),
    .opnd       (opnd)
  );

  // Row dot products
  interface_mac_stage mac_stage_i (
    .CLK        (CLK),
    .RST        (RST),
    .opnd_valid (opnd_valid),
    .opnd       (opnd),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  // Q8 result words
  interface_result_scaler result_scaler_i (
    .CLK        (CLK),
    .RST        (RST),
    .sum_valid  (sum_valid),
    .sum        (sum),
    .xi_valid   (xi_valid),
    .xi         (xi),
    .done       (done)
  );

endmodule

`default_nettype wire

/* logic/interface_result_scaler.sv */
`default_nettype none

`include "dnc_read_params.svh"

module interface_result_scaler (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    sum_valid,
  input  dnc_read_pkg::row_sum_t  sum,
  output logic                    xi_valid,
  output dnc_read_pkg::xi_entry_t xi,
  output logic                    done
);

  //////////////////////////////////////////////////////////////////////
  // Rescale and saturate
  //////////////////////////////////////////////////////////////////////

  logic signed [`DNC_ACC_WIDTH-1:0]                 shifted;
  logic        [`DNC_ACC_WIDTH-`DNC_DATA_WIDTH:0]   upper;
  logic                                             fits;
  logic        [`DNC_DATA_WIDTH-1:0]                sat_value;

  // Back from Q16 to Q8
  assign shifted = $signed(sum.sum) >>> `DNC_FRAC_BITS;

  // Sign bit of the result and everything above it
  assign upper = shifted[`DNC_ACC_WIDTH-1:`DNC_DATA_WIDTH-1];
  // All ones or all zeros, no overflow
  assign fits = (upper == '0) || (upper == '1);

  // Clamp toward the sign of the sum
  assign sat_value = fits             ? shifted[`DNC_DATA_WIDTH-1:0] :
                     shifted[`DNC_ACC_WIDTH-1] ? {1'b1, {(`DNC_DATA_WIDTH-1){1'b0}}} :
                                                  {1'b0, {(`DNC_DATA_WIDTH-1){1'b1}}};

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      xi_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      xi_valid <= sum_valid;
      // Last row closes the pass
      done     <= sum_valid && sum.tag.row_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (sum_valid) begin
      xi.field <= sum.tag.field;
      xi.head  <= sum.tag.head;
      xi.elem  <= sum.tag.elem;
      xi.value <= sat_value;
    end
  end

endmodule

`default_nettype wire

/* logic/interface_mac_stage.sv */
`default_nettype none

`include "dnc_read_params.svh"

module interface_mac_stage (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   opnd_valid,
  input  dnc_read_pkg::operand_t opnd,
  output logic                   sum_valid,
  output dnc_read_pkg::row_sum_t sum
);

  //////////////////////////////////////////////////////////////////////
  // Multiply
  //////////////////////////////////////////////////////////////////////

  logic                   prod_valid;
  dnc_read_pkg::product_t prod;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= opnd_valid;
    end
  end

  // Q8 times Q8, full 32-bit product
  always_ff @(posedge CLK) begin
    if (opnd_valid) begin
      prod.tag       <= opnd.tag;
      prod.beat_last <= opnd.beat_last;
      prod.product   <= $signed(opnd.weight) * $signed(opnd.hidden);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////////////////////////

  logic                             row_start;
  logic signed [`DNC_ACC_WIDTH-1:0] acc;
  logic signed [`DNC_ACC_WIDTH-1:0] prod_ext;
  logic signed [`DNC_ACC_WIDTH-1:0] acc_next;

  // Sign extend to the guard bits
  assign prod_ext = {{(`DNC_ACC_WIDTH - 2*`DNC_DATA_WIDTH){prod.product[2*`DNC_DATA_WIDTH-1]}},
                     prod.product};

  // First beat of a row restarts the sum
  assign acc_next = row_start ? prod_ext : acc + prod_ext;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_start <= 1'b1;
      sum_valid <= 1'b0;
    end else begin
      if (prod_valid) begin
        row_start <= prod.beat_last;
      end
      // One sum per row
      sum_valid <= prod_valid && prod.beat_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (prod_valid) begin
      acc <= acc_next;
      if (prod.beat_last) begin
        sum.tag <= prod.tag;
        sum.sum <= acc_next;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/interface_operand_fetch.sv */
`default_nettype none

`include "dnc_read_params.svh"

module interface_operand_fetch (
  input  logic                        CLK,
  input  logic                        RST,
  // Weight write port
  input  logic                        w_wr,
  input  logic [`DNC_WADDR_BITS-1:0]  w_addr,
  input  logic [`DNC_DATA_WIDTH-1:0]  w_data,
  // Hidden vector write port
  input  logic                        h_wr,
  input  logic [`DNC_HIDDEN_BITS-1:0] h_addr,
  input  logic [`DNC_DATA_WIDTH-1:0]  h_data,
  // From the sequencer
  input  logic                        beat_valid,
  input  dnc_read_pkg::row_beat_t     beat,
  // To the MAC stage
  output logic                        opnd_valid,
  output dnc_read_pkg::operand_t      opnd
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // U, row-major, L words per row
  logic [`DNC_DATA_WIDTH-1:0] weight_mem [`DNC_ROW_COUNT*`DNC_HIDDEN_SIZE];
  // h
  logic [`DNC_DATA_WIDTH-1:0] hidden_reg [`DNC_HIDDEN_SIZE];

  logic [`DNC_WADDR_BITS-1:0] rd_addr;

  // Row times L plus hidden index
  assign rd_addr = `DNC_WADDR_BITS'(beat.row) * `DNC_WADDR_BITS'(`DNC_HIDDEN_SIZE)
                 + `DNC_WADDR_BITS'(beat.hid_index);

  // Host strobes
  always_ff @(posedge CLK) begin
    if (w_wr) begin
      weight_mem[w_addr] <= w_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (h_wr) begin
      hidden_reg[h_addr] <= h_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      opnd_valid <= 1'b0;
    end else begin
      opnd_valid <= beat_valid;
    end
  end

  // Weight and hidden element for this beat, tag follows along
  always_ff @(posedge CLK) begin
    if (beat_valid) begin
      opnd.tag       <= beat.tag;
      opnd.beat_last <= beat.beat_last;
      opnd.weight    <= weight_mem[rd_addr];
      opnd.hidden    <= hidden_reg[beat.hid_index];
    end
  end

endmodule

`default_nettype wire

/* logic/interface_row_sequencer.sv */
`default_nettype none

`include "dnc_read_params.svh"

module interface_row_sequencer (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  output logic                    busy,
  output logic                    beat_valid,
  output dnc_read_pkg::row_beat_t beat
);

  //////////////////////////////////////////////////////////////////////
  // Counters for the next beat
  //////////////////////////////////////////////////////////////////////

  logic                        active;
  logic [`DNC_ROW_BITS-1:0]    row_cnt;
  logic [`DNC_HIDDEN_BITS-1:0] hid_cnt;
  dnc_read_pkg::xi_field_t     field_cnt;
  logic                        head_cnt;
  logic [1:0]                  elem_cnt;

  logic       hid_wrap;
  logic       row_final;
  logic       head_wrap;
  logic [1:0] elem_limit;

  // End of a row, end of the pass
  assign hid_wrap  = (hid_cnt == `DNC_HIDDEN_BITS'(`DNC_HIDDEN_SIZE - 1));
  assign row_final = (row_cnt == `DNC_ROW_BITS'(`DNC_ROW_COUNT - 1));
  assign head_wrap = (head_cnt == 1'(`DNC_READ_HEADS - 1));

  // Elements per head depend on the field
  always_comb begin
    case (field_cnt)
      dnc_read_pkg::FIELD_KEY:  elem_limit = 2'(`DNC_WORD_SIZE - 1);
      dnc_read_pkg::FIELD_MODE: elem_limit = 2'(`DNC_MODE_COUNT - 1);
      default:                  elem_limit = 2'd0;
    endcase
  end

  // Outstanding beats keep the unit busy
  assign busy = beat_valid;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active     <= 1'b0;
      beat_valid <= 1'b0;
      row_cnt    <= '0;
      hid_cnt    <= '0;
      field_cnt  <= dnc_read_pkg::FIELD_KEY;
      head_cnt   <= 1'b0;
      elem_cnt   <= '0;
    end else if (!active) begin
      beat_valid <= 1'b0;
      // Accept START only when idle
      if (start && !busy) begin
        active    <= 1'b1;
        row_cnt   <= '0;
        hid_cnt   <= '0;
        field_cnt <= dnc_read_pkg::FIELD_KEY;
        head_cnt  <= 1'b0;
        elem_cnt  <= '0;
      end
    end else begin
      beat_valid <= 1'b1;
      if (hid_wrap) begin
        hid_cnt <= '0;
        row_cnt <= row_cnt + 1'b1;
        if (row_final) begin
          active <= 1'b0;
        end
        // Step element, then head, then field
        if (elem_cnt == elem_limit) begin
          elem_cnt <= '0;
          if (head_wrap) begin
            head_cnt  <= 1'b0;
            field_cnt <= dnc_read_pkg::xi_field_t'(field_cnt + 2'd1);
          end else begin
            head_cnt <= head_cnt + 1'b1;
          end
        end else begin
          elem_cnt <= elem_cnt + 2'd1;
        end
      end else begin
        hid_cnt <= hid_cnt + 1'b1;
      end
    end
  end

  // Beat payload
  always_ff @(posedge CLK) begin
    if (active) begin
      beat.tag.field    <= field_cnt;
      beat.tag.head     <= head_cnt;
      beat.tag.elem     <= elem_cnt;
      beat.tag.row_last <= row_final;
      beat.row          <= row_cnt;
      beat.hid_index    <= hid_cnt;
      beat.beat_last    <= hid_wrap;
    end
  end

endmodule

`default_nettype wire

/* logic/dnc_read_pkg.sv */
`default_nettype none

`include "dnc_read_params.svh"

package dnc_read_pkg;

  //////////////////////////////////////////////////////////////////////
  // Interface vector fields
  //////////////////////////////////////////////////////////////////////

  // Row order of the interface vector
  typedef enum logic [1:0] {
    FIELD_KEY      = 2'd0,
    FIELD_STRENGTH = 2'd1,
    FIELD_FREE     = 2'd2,
    FIELD_MODE     = 2'd3
  } xi_field_t;

  // Where a row lands in the interface vector
  typedef struct packed {
    xi_field_t  field;
    logic       head;      // R = 2
    logic [1:0] elem;      // up to W - 1
    logic       row_last;  // last row of the pass
  } xi_tag_t;

  //////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////////////////////////

  // Sequencer to operand fetch
  typedef struct packed {
    xi_tag_t                     tag;
    logic [`DNC_ROW_BITS-1:0]    row;
    logic [`DNC_HIDDEN_BITS-1:0] hid_index;
    logic                        beat_last;  // hidden index L-1
  } row_beat_t;

  // Operand fetch to multiplier
  typedef struct packed {
    xi_tag_t                          tag;
    logic                             beat_last;
    logic signed [`DNC_DATA_WIDTH-1:0] weight;
    logic signed [`DNC_DATA_WIDTH-1:0] hidden;
  } operand_t;

  // Multiplier to accumulator, full precision
  typedef struct packed {
    xi_tag_t                             tag;
    logic                                beat_last;
    logic signed [2*`DNC_DATA_WIDTH-1:0] product;
  } product_t;

  // Accumulator to scaler
  typedef struct packed {
    xi_tag_t                          tag;
    logic signed [`DNC_ACC_WIDTH-1:0] sum;
  } row_sum_t;

  // Output word
  typedef struct packed {
    xi_field_t                         field;
    logic                              head;
    logic [1:0]                        elem;
    logic signed [`DNC_DATA_WIDTH-1:0] value;
  } xi_entry_t;

endpackage

`default_nettype wire

/* logic/dnc_read_params.svh */
`ifndef DNC_READ_PARAMS_SVH
`define DNC_READ_PARAMS_SVH

// Controller hidden vector length (L)
`define DNC_HIDDEN_SIZE 4
// Read heads (R)
`define DNC_READ_HEADS 2
// Key length per head (W)
`define DNC_WORD_SIZE 4
// Read modes per head: backward, content, forward
`define DNC_MODE_COUNT 3
// Interface rows, R*W keys + R strengths + R free gates + 3R modes
`define DNC_ROW_COUNT 18

// Signed fixed point
`define DNC_DATA_WIDTH 16
`define DNC_FRAC_BITS 8
`define DNC_ACC_WIDTH 36

// Counter and address widths
`define DNC_ROW_BITS 5
`define DNC_HIDDEN_BITS 2
`define DNC_WADDR_BITS 7

`endif
